// File: all.f
verilog/cache_sync_pkg.sv
verilog/dcache_line_walker.sv
verilog/cache_sync_engine.sv
verilog/icache_line_store.sv
verilog/fence_sync_top.sv
tb/fence_sync_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fence.i sync testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fence_sync_tb -f all.f

out=$(./obj_dir/Vfence_sync_tb)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// File: tb/fence_sync_tb.sv
// testbench for the fence.i cache sync subsystem
// stores random lines, requests fences and checks icache fetches
// against a reference model of both caches

`timescale 1ns/1ps
`default_nettype none

module fence_sync_tb;

  import cache_sync_pkg::*;

  localparam int DC_LINES    = 16;
  localparam int IC_LINES    = 32;
  localparam int DC_IDX_W    = $clog2(DC_LINES);
  localparam int IC_IDX_W    = $clog2(IC_LINES);
  localparam int CLK_PERIOD  = 100;
  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 2000;

  logic  clk = 1'b0;
  logic  rst;
  logic  fencei_req;
  logic  fencei_ack;
  logic  st_valid;
  etag_t st_etag;
  line_t st_data;
  logic  fetch_req;
  etag_t fetch_etag;
  logic  fetch_valid;
  logic  fetch_hit;
  line_t fetch_data;

  // dcache model as stored
  logic  dc_vld [DC_LINES];
  etag_t dc_tag [DC_LINES];
  line_t dc_dat [DC_LINES];
  // icache model as of the last fence
  logic  ic_vld [IC_LINES];
  etag_t ic_tag [IC_LINES];
  line_t ic_dat [IC_LINES];

  // expected fetch results in issue order
  logic   exp_hit_q  [$];
  line_t  exp_data_q [$];
  // every tag stored so far
  etag_t  tags [$];

  integer seed = 94;
  int     errors = 0;
  int     test_base = 0;
  int     test_num = 1;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  logic   fetch_d = 1'b0;
  logic   in_fence = 1'b0;

  fence_sync_top #(
    .DC_LINES (DC_LINES),
    .IC_LINES (IC_LINES)
  ) u_fence_sync_top (
    .clk           (clk),
    .rst           (rst),
    .i_fencei_req  (fencei_req),
    .o_fencei_ack  (fencei_ack),
    .i_st_valid    (st_valid),
    .i_st_etag     (st_etag),
    .i_st_data     (st_data),
    .i_fetch_req   (fetch_req),
    .i_fetch_etag  (fetch_etag),
    .o_fetch_valid (fetch_valid),
    .o_fetch_hit   (fetch_hit),
    .o_fetch_data  (fetch_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic etag_t random_tag();
    logic [31:0] r;
    r = $random(seed);
    return r[27:0];
  endfunction

  function automatic line_t random_line();
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    w0 = $random(seed);
    w1 = $random(seed);
    w2 = $random(seed);
    w3 = $random(seed);
    return {w3, w2, w1, w0};
  endfunction

  // expected hit and data from the icache model
  function automatic logic expected_fetch(input etag_t tag, output line_t data);
    logic [IC_IDX_W-1:0] idx;
    idx  = tag[IC_IDX_W-1:0];
    data = ic_dat[idx];
    return ic_vld[idx] && (ic_tag[idx] == tag);
  endfunction

  // all tasks start and end 1 ns after a rising edge
  task automatic store_line(input etag_t tag, input line_t data);
    st_valid = 1'b1;
    st_etag  = tag;
    st_data  = data;
    @(posedge clk);
    #1;
    st_valid = 1'b0;
    // last store per index wins
    dc_vld[tag[DC_IDX_W-1:0]] = 1'b1;
    dc_tag[tag[DC_IDX_W-1:0]] = tag;
    dc_dat[tag[DC_IDX_W-1:0]] = data;
    tags.push_back(tag);
  endtask

  task automatic fetch_line(input etag_t tag);
    logic  hit;
    line_t data;
    hit = expected_fetch(tag, data);
    exp_hit_q.push_back(hit);
    exp_data_q.push_back(data);
    fetch_req  = 1'b1;
    fetch_etag = tag;
    @(posedge clk);
    #1;
    fetch_req = 1'b0;
  endtask

  task automatic fetch_all();
    foreach (tags[i]) begin
      fetch_line(tags[i]);
    end
  endtask

  // request held until the ack with no cycle limit
  task automatic run_fence();
    in_fence   = 1'b1;
    fencei_req = 1'b1;
    @(posedge clk);
    #1;
    while (!fencei_ack) begin
      @(posedge clk);
      #1;
    end
    fencei_req = 1'b0;
    @(posedge clk);
    #1;
    assert (!fencei_ack) else begin
      $display("%0t: fence acknowledge lasted more than one cycle", $time);
      errors++;
    end
    in_fence = 1'b0;
    // icache model takes every valid dcache line
    for (int i = 0; i < DC_LINES; i++) begin
      if (dc_vld[i]) begin
        ic_vld[dc_tag[i][IC_IDX_W-1:0]] = 1'b1;
        ic_tag[dc_tag[i][IC_IDX_W-1:0]] = dc_tag[i];
        ic_dat[dc_tag[i][IC_IDX_W-1:0]] = dc_dat[i];
      end
    end
  endtask

  task automatic finish_test(input string name);
    // last fetch still on its way to the checker
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    if (errors == test_base) begin
      pass_cnt++;
      $display("test %0d %s: pass", test_num, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: fail, %0d errors", test_num, name, errors - test_base);
    end
    test_base = errors;
    test_num++;
  endtask

  always @(posedge clk) begin
    fetch_d <= fetch_req;
  end

  // outputs sampled mid-cycle on the falling edge
  always @(negedge clk) begin : check_outputs
    logic  exp_hit;
    line_t exp_data;
    if (!rst) begin
      assert (fetch_valid == fetch_d) else begin
        $display("mismatch at %0t: o_fetch_valid expected %0b actual %0b",
                 $time, fetch_d, fetch_valid);
        errors++;
      end
      assert (in_fence || !fencei_ack) else begin
        $display("%0t: fence acknowledged with no fence requested", $time);
        errors++;
      end
      if (fetch_valid && exp_hit_q.size() == 0) begin
        $display("%0t: fetch response with no fetch outstanding", $time);
        errors++;
      end else if (fetch_valid) begin
        exp_hit  = exp_hit_q.pop_front();
        exp_data = exp_data_q.pop_front();
        assert (fetch_hit == exp_hit) else begin
          $display("mismatch at %0t: o_fetch_hit expected %0b actual %0b",
                   $time, exp_hit, fetch_hit);
          errors++;
        end
        // data only defined on a hit
        if (exp_hit) begin
          assert (fetch_data == exp_data) else begin
            $display("mismatch at %0t: o_fetch_data expected %h actual %h",
                     $time, exp_data, fetch_data);
            errors++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish in %0d cycles", N_TESTS * TEST_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    etag_t t;
    etag_t old_t;
    rst        = 1'b1;
    fencei_req = 1'b0;
    st_valid   = 1'b0;
    st_etag    = '0;
    st_data    = '0;
    fetch_req  = 1'b0;
    fetch_etag = '0;
    for (int i = 0; i < DC_LINES; i++) begin
      dc_vld[i] = 1'b0;
      dc_tag[i] = '0;
      dc_dat[i] = '0;
    end
    for (int i = 0; i < IC_LINES; i++) begin
      ic_vld[i] = 1'b0;
      ic_tag[i] = '0;
      ic_dat[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;

    // empty icache so every fetch misses
    for (int i = 0; i < 8; i++) begin
      fetch_line(random_tag());
    end
    finish_test("fetch after reset");

    // stores to even dcache indices stay out of the icache
    for (int i = 0; i < 8; i++) begin
      t = random_tag();
      t[DC_IDX_W-1:0] = DC_IDX_W'(2 * i);
      store_line(t, random_line());
    end
    fetch_all();
    finish_test("store before fence");

    run_fence();
    fetch_all();
    finish_test("first fence");

    // new tag at the same icache index with the top tag bit flipped
    for (int i = 0; i < 3; i++) begin
      old_t = tags[i];
      t = random_tag();
      t[IC_IDX_W-1:0] = old_t[IC_IDX_W-1:0];
      t[27] = ~old_t[27];
      store_line(t, random_line());
    end
    run_fence();
    fetch_all();
    finish_test("overwrite and fence");

    run_fence();
    fetch_all();
    finish_test("fence with no new stores");

    // two new lines and then two fences back to back
    for (int i = 0; i < 2; i++) begin
      t = random_tag();
      t[DC_IDX_W-1:0] = DC_IDX_W'(9 + 2 * i);
      store_line(t, random_line());
    end
    run_fence();
    run_fence();
    fetch_all();
    finish_test("back-to-back fences");

    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             pass_cnt, fail_cnt, errors);
    if (errors == 0 && fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/fence_sync_top.sv
// fence.i coherence subsystem top level
// dcache walker -> sync engine -> icache, depths set here and passed down
// stores go to the dcache only, fetches read the icache

`timescale 1ns/1ps
`default_nettype none

module fence_sync_top #(
  // powers of two, IC_LINES >= DC_LINES
  parameter int DC_LINES = cache_sync_pkg::DEF_DC_LINES,
  parameter int IC_LINES = cache_sync_pkg::DEF_IC_LINES
) (
  input  logic                  clk,
  input  logic                  rst,
  // fence.i
  input  logic                  i_fencei_req,
  output logic                  o_fencei_ack,
  // store port into the dcache
  input  logic                  i_st_valid,
  input  cache_sync_pkg::etag_t i_st_etag,
  input  cache_sync_pkg::line_t i_st_data,
  // fetch port from the icache
  input  logic                  i_fetch_req,
  input  cache_sync_pkg::etag_t i_fetch_etag,
  output logic                  o_fetch_valid,
  output logic                  o_fetch_hit,
  output cache_sync_pkg::line_t o_fetch_data
);

  import cache_sync_pkg::*;

  // walker <-> engine
  logic  rreq;
  logic  rack;
  logic  rpackreq;
  logic  rpackack;
  etag_t retag;
  line_t rdata;

  // engine <-> icache
  logic  wreq;
  logic  wack;
  etag_t wetag;
  line_t wdata;

  dcache_line_walker #(
    .DC_LINES (DC_LINES)
  ) u_dcache_line_walker (
    .clk        (clk),
    .rst        (rst),
    .i_st_valid (i_st_valid),
    .i_st_etag  (i_st_etag),
    .i_st_data  (i_st_data),
    .i_rreq     (rreq),
    .o_rack     (rack),
    .o_rpackreq (rpackreq),
    .i_rpackack (rpackack),
    .o_retag    (retag),
    .o_rdata    (rdata)
  );

  cache_sync_engine u_cache_sync_engine (
    .clk          (clk),
    .rst          (rst),
    .i_fencei_req (i_fencei_req),
    .o_fencei_ack (o_fencei_ack),
    .o_rreq       (rreq),
    .i_rack       (rack),
    .i_rpackreq   (rpackreq),
    .o_rpackack   (rpackack),
    .i_retag      (retag),
    .i_rdata      (rdata),
    .o_wreq       (wreq),
    .i_wack       (wack),
    .o_wetag      (wetag),
    .o_wdata      (wdata)
  );

  icache_line_store #(
    .IC_LINES (IC_LINES)
  ) u_icache_line_store (
    .clk           (clk),
    .rst           (rst),
    .i_wreq        (wreq),
    .o_wack        (wack),
    .i_wetag       (wetag),
    .i_wdata       (wdata),
    .i_fetch_req   (i_fetch_req),
    .i_fetch_etag  (i_fetch_etag),
    .o_fetch_valid (o_fetch_valid),
    .o_fetch_hit   (o_fetch_hit),
    .o_fetch_data  (o_fetch_data)
  );

endmodule

`default_nettype wire

// File: verilog/icache_line_store.sv
// direct-mapped instruction cache line array
// lines arrive from the sync engine over a req/ack write handshake;
// the fetch port returns hit and data one cycle after the request

`timescale 1ns/1ps
`default_nettype none

module icache_line_store #(
  parameter int IC_LINES = cache_sync_pkg::DEF_IC_LINES
) (
  input  logic                  clk,
  input  logic                  rst,
  // write handshake from the sync engine
  input  logic                  i_wreq,
  output logic                  o_wack,
  input  cache_sync_pkg::etag_t i_wetag,
  input  cache_sync_pkg::line_t i_wdata,
  // fetch port
  input  logic                  i_fetch_req,
  input  cache_sync_pkg::etag_t i_fetch_etag,
  output logic                  o_fetch_valid,
  output logic                  o_fetch_hit,
  output cache_sync_pkg::line_t o_fetch_data
);

  import cache_sync_pkg::*;

  localparam int IDX_W = $clog2(IC_LINES);

  etag_t                tag_mem  [IC_LINES];
  line_t                data_mem [IC_LINES];
  logic  [IC_LINES-1:0] valid_q;

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] fe_idx;
  logic             wr_en;

  assign wr_idx = i_wetag[IDX_W-1:0];
  assign fe_idx = i_fetch_etag[IDX_W-1:0];
  // one write per request, wack high blocks a second one
  assign wr_en  = i_wreq & ~o_wack;

  // line write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx]  <= i_wetag;
      data_mem[wr_idx] <= i_wdata;
    end
  end

  // valid bits and write ack
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      o_wack  <= 1'b0;
    end else begin
      o_wack <= wr_en;
      if (wr_en) begin
        valid_q[wr_idx] <= 1'b1;
      end
    end
  end

  // fetch, tag compare registered along with data
  always_ff @(posedge clk) begin
    if (rst) begin
      o_fetch_valid <= 1'b0;
      o_fetch_hit   <= 1'b0;
    end else begin
      o_fetch_valid <= i_fetch_req;
      o_fetch_hit   <= i_fetch_req && valid_q[fe_idx] && (tag_mem[fe_idx] == i_fetch_etag);
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetch_req) begin
      o_fetch_data <= data_mem[fe_idx];
    end
  end

endmodule

`default_nettype wire

// File: verilog/cache_sync_engine.sv
// fence.i sync engine
// on a request, holds a read request to the dcache walker, copies each
// packet it offers into the icache and acks the packet; the fence is
// acked with a one-cycle pulse once the walker reports the sweep done

`timescale 1ns/1ps
`default_nettype none

module cache_sync_engine (
  input  logic                  clk,
  input  logic                  rst,
  // fence.i request / ack
  input  logic                  i_fencei_req,
  output logic                  o_fencei_ack,
  // dcache walker, read handshake
  output logic                  o_rreq,
  input  logic                  i_rack,
  // dcache walker, packet handshake
  input  logic                  i_rpackreq,
  output logic                  o_rpackack,
  input  cache_sync_pkg::etag_t i_retag,
  input  cache_sync_pkg::line_t i_rdata,
  // icache write handshake
  output logic                  o_wreq,
  input  logic                  i_wack,
  output cache_sync_pkg::etag_t o_wetag,
  output cache_sync_pkg::line_t o_wdata
);

  import cache_sync_pkg::*;

  sync_state_t state;
  logic        hs_rd;
  logic        hs_wr;

  // handshake completions
  assign hs_rd = o_rreq & i_rack;
  assign hs_wr = o_wreq & i_wack;

  // next state
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          // no restart in the ack cycle, request may still be high
          if (i_fencei_req && !o_fencei_ack) begin
            state <= SYNC_READ;
          end
        end
        SYNC_READ: begin
          // packet wins, walker never offers one with rack
          if (i_rpackreq) begin
            state <= SYNC_WRITE;
          end else if (hs_rd) begin
            state <= IDLE;
          end
        end
        SYNC_WRITE: begin
          if (hs_wr) begin
            state <= RPACK_ACK;
          end
        end
        RPACK_ACK: begin
          // wait for the walker to let go of the packet
          if (!i_rpackreq) begin
            state <= SYNC_READ;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // handshake outputs
  always_ff @(posedge clk) begin
    if (rst) begin
      o_fencei_ack <= 1'b0;
      o_rreq       <= 1'b0;
      o_rpackack   <= 1'b0;
      o_wreq       <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          o_fencei_ack <= 1'b0;
        end
        SYNC_READ: begin
          if (hs_rd) begin
            // sweep done, release walker and ack the fence
            o_rreq       <= 1'b0;
            o_fencei_ack <= 1'b1;
          end else begin
            o_rreq <= 1'b1;
          end
        end
        SYNC_WRITE: begin
          if (hs_wr) begin
            o_wreq     <= 1'b0;
            o_rpackack <= 1'b1;
          end else begin
            o_wreq <= 1'b1;
          end
        end
        RPACK_ACK: begin
          // single-cycle packet ack
          o_rpackack <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  // write payload, captured from the walker packet
  always_ff @(posedge clk) begin
    if (state == SYNC_READ && i_rpackreq) begin
      o_wetag <= i_retag;
      o_wdata <= i_rdata;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dcache_line_walker.sv
// small data cache line array with a single-cycle store port
// on a read request every index is swept in ascending order and each
// valid line is offered as a tag + data packet; o_rack pulses at the end

`timescale 1ns/1ps
`default_nettype none

module dcache_line_walker #(
  parameter int DC_LINES = cache_sync_pkg::DEF_DC_LINES
) (
  input  logic                  clk,
  input  logic                  rst,
  // store port
  input  logic                  i_st_valid,
  input  cache_sync_pkg::etag_t i_st_etag,
  input  cache_sync_pkg::line_t i_st_data,
  // read handshake
  input  logic                  i_rreq,
  output logic                  o_rack,
  // packet handshake
  output logic                  o_rpackreq,
  input  logic                  i_rpackack,
  output cache_sync_pkg::etag_t o_retag,
  output cache_sync_pkg::line_t o_rdata
);

  import cache_sync_pkg::*;

  localparam int                IDX_W    = $clog2(DC_LINES);
  localparam logic [IDX_W-1:0]  LAST_IDX = IDX_W'(DC_LINES - 1);

  // line arrays, only the valid bits are control state
  etag_t                tag_mem  [DC_LINES];
  line_t                data_mem [DC_LINES];
  logic  [DC_LINES-1:0] valid_q;

  logic [IDX_W-1:0] rd_idx;
  // set once the last index has been passed, rack goes out next cycle
  logic             scan_done;
  logic             sweeping;
  logic [IDX_W-1:0] st_idx;

  // walker busy from the read request until the rack pulse
  assign sweeping = i_rreq | o_rpackreq | scan_done;
  assign st_idx   = i_st_etag[IDX_W-1:0];

  // store port, ignored mid-sweep
  always_ff @(posedge clk) begin
    if (i_st_valid && !sweeping) begin
      tag_mem[st_idx]  <= i_st_etag;
      data_mem[st_idx] <= i_st_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (i_st_valid && !sweeping) begin
      valid_q[st_idx] <= 1'b1;
    end
  end

  // sweep control
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_idx     <= '0;
      scan_done  <= 1'b0;
      o_rpackreq <= 1'b0;
      o_rack     <= 1'b0;
    end else begin
      // rack is a one-cycle pulse
      o_rack <= 1'b0;
      if (o_rpackreq) begin
        // packet out, hold it until the engine acks
        if (i_rpackack) begin
          o_rpackreq <= 1'b0;
          if (rd_idx == LAST_IDX) begin
            rd_idx    <= '0;
            scan_done <= 1'b1;
          end else begin
            rd_idx <= rd_idx + 1'b1;
          end
        end
      end else if (scan_done) begin
        o_rack    <= 1'b1;
        scan_done <= 1'b0;
      end else if (i_rreq && !o_rack) begin
        // rreq is still high during the rack cycle, so no restart there
        if (valid_q[rd_idx]) begin
          o_rpackreq <= 1'b1;
        end else if (rd_idx == LAST_IDX) begin
          rd_idx    <= '0;
          scan_done <= 1'b1;
        end else begin
          // skip invalid line
          rd_idx <= rd_idx + 1'b1;
        end
      end
    end
  end

  // packet payload, loaded as the request goes up and stable until acked
  always_ff @(posedge clk) begin
    if (!o_rpackreq && !scan_done && i_rreq && !o_rack && valid_q[rd_idx]) begin
      o_retag <= tag_mem[rd_idx];
      o_rdata <= data_mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

// File: verilog/cache_sync_pkg.sv
// shared types and default depths for the fence.i cache sync subsystem
// imported by the walker, sync engine, icache store and top level

`default_nettype none

package cache_sync_pkg;

  // one cache line, 16 bytes
  typedef logic [127:0] line_t;

  // line tag = byte address bits 31..4
  // low tag bits pick the cache index
  typedef logic [27:0] etag_t;

  // sync engine states
  // IDLE        waiting for a fresh fence.i request
  // SYNC_READ   read request held, waiting on a packet or the end of the sweep
  // SYNC_WRITE  packet held, writing it into the icache
  // RPACK_ACK   packet acked, waiting for the walker to drop its request
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    SYNC_READ  = 2'd1,
    SYNC_WRITE = 2'd2,
    RPACK_ACK  = 2'd3
  } sync_state_t;

  // default depths, both powers of two
  // icache must be at least as deep as the dcache
  localparam int DEF_DC_LINES = 16;
  localparam int DEF_IC_LINES = 32;

endpackage

`default_nettype wire
